/* Makefile */
# Verilator build and run of the microCore testbench

SIM := obj_dir/VtbMicroCore
SOURCES := $(shell cat vlog.f)

.PHONY: run clean

# The run passes only if the testbench printed its pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

# Rebuilt only when a source or the file list changes
$(SIM): vlog.f $(SOURCES)
	verilator --binary -j 0 --top-module tbMicroCore -f vlog.f

clean:
	rm -rf obj_dir

/* hdl/aluUnit.sv */
`timescale 1ns/100ps

module aluUnit import cpuPkg::*; (
    input  aluOp_t     aluOp,
    input  logic [7:0] a,
    input  logic [7:0] b,
    output logic [7:0] result,
    output logic       zero
);

    // Sums and differences wrap at 8 bits
    always_comb
    begin
        case (aluOp)
            ALU_ADD:
            begin
                result = a + b;
            end
            ALU_SUB:
            begin
                result = a - b;
            end
            ALU_AND:
            begin
                result = a & b;
            end
            ALU_OR:
            begin
                result = a | b;
            end
            ALU_XOR:
            begin
                result = a ^ b;
            end
            default:
            begin
                result = 8'd0;
            end
        endcase
    end

    // Sampled by the executor for JZ
    assign zero = (result == 8'd0);

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

    ////////////////////////////////////////////////////////////
    // Sizes shared by the core and the memory
    ////////////////////////////////////////////////////////////
    localparam int MEM_WORDS = 256;
    localparam int NUM_REGS = 8;

    // Codes 13 to 15 decode as no-operation
    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        LDI  = 4'h5,
        LD   = 4'h6,
        ST   = 4'h7,
        JMP  = 4'h8,
        JZ   = 4'h9,
        CALL = 4'ha,
        JR   = 4'hb,
        HALT = 4'hc
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } aluOp_t;

    // Register file write select
    typedef enum logic [1:0] {
        NONE   = 2'b00,
        RESULT = 2'b01,
        DATA   = 2'b10,
        LINK   = 2'b11
    } wrSel_t;

    ////////////////////////////////////////////////////////////
    // Instruction word, seen two ways
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] rz;
        logic [2:0] rx;
        logic [2:0] ry;
        logic [2:0] spare;
    } regView_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] rz;
        logic       pad;
        logic [7:0] imm;
    } immView_t;

    typedef union packed {
        regView_t regView;
        immView_t immView;
    } instrWord_t;

    // One peer's request toward the memory arbiter
    typedef struct packed {
        logic        req;
        logic        we;
        logic [7:0]  addr;
        logic [15:0] wdata;
    } memReq_t;

endpackage

/* hdl/execUnit.sv */
`timescale 1ns/100ps

module execUnit import cpuPkg::*; (
    input  logic        reset,
    input  logic        clk,
    input  logic        run,
    input  instrWord_t  instruction,
    input  logic        instrValid,
    output logic        take,
    output logic        redirect,
    output logic [7:0]  target,
    output logic [2:0]  rxAddr,
    output logic [2:0]  ryAddr,
    output logic [2:0]  rzAddr,
    output wrSel_t      wrSel,
    output logic [7:0]  wrData,
    output aluOp_t      aluOp,
    input  logic [7:0]  aluResult,
    input  logic        aluZero,
    input  logic [7:0]  rxData,
    input  logic [7:0]  ryData,
    output memReq_t     execReq,
    input  logic        execGrant,
    input  logic        execRdValid,
    input  logic [15:0] rdata,
    output logic        halted
);

    typedef enum logic [2:0] {IDLE, DECODE, OPERAND, MEMORY, STOP} state_t;

    state_t      state;
    state_t      stateNext;
    instrWord_t  ir;
    opcode_t     op;
    logic        zeroFlag;
    logic        memGranted;
    logic [7:0]  memAddr;
    logic [15:0] memWdata;

    assign op = ir.regView.opcode;
    assign take = (state == DECODE) && run && instrValid;
    assign halted = (state == STOP);

    // Operands are read from the buffer while decoding so they are ready in OPERAND
    assign rxAddr = (state == DECODE) ? instruction.regView.rx : ir.regView.rx;
    assign ryAddr = (state == DECODE) ? instruction.regView.ry : ir.regView.ry;
    assign rzAddr = ir.regView.rz;

    assign execReq = '{req: (state == MEMORY) && !memGranted && run,
                       we: (op == ST), addr: memAddr, wdata: memWdata};

    always_comb
    begin
        case (op)
            SUB:     aluOp = ALU_SUB;
            AND:     aluOp = ALU_AND;
            OR:      aluOp = ALU_OR;
            XOR:     aluOp = ALU_XOR;
            default: aluOp = ALU_ADD;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        stateNext = state;
        redirect = 1'b0;
        target = ir.immView.imm;
        wrSel = NONE;
        wrData = ir.immView.imm;
        case (state)
            IDLE:
            begin
                if (run)
                    stateNext = DECODE;
            end
            DECODE:
            begin
                if (take)
                begin
                    stateNext = OPERAND;
                    // nextPc still refers to the CALL itself here
                    if (instruction.regView.opcode == CALL)
                        wrSel = LINK;
                end
            end
            OPERAND:
            begin
                stateNext = DECODE;
                case (op)
                    ADD, SUB, AND, OR, XOR: wrSel = RESULT;
                    LDI:       wrSel = DATA;
                    LD, ST:    stateNext = MEMORY;
                    JMP, CALL: redirect = 1'b1;
                    JZ:        redirect = zeroFlag;
                    JR:
                    begin
                        redirect = 1'b1;
                        target = rxData;
                    end
                    HALT:      stateNext = STOP;
                    default:   ;
                endcase
            end
            MEMORY:
            begin
                if (op == ST && execGrant)
                    stateNext = DECODE;
                else if (op == LD && execRdValid)
                begin
                    // Low byte of the word goes to rz
                    wrSel = DATA;
                    wrData = rdata[7:0];
                    stateNext = DECODE;
                end
            end
            default: ;
        endcase
        if (!run)
        begin
            stateNext = IDLE;
            wrSel = NONE;
            redirect = 1'b0;
        end
    end

    always_ff @(posedge reset or posedge clk)
    begin
        if (clk)
        begin
            state <= IDLE;
            zeroFlag <= 1'b0;
            memGranted <= 1'b0;
        end
        else
        begin
            state <= stateNext;
            if (state == OPERAND && wrSel == RESULT)
                zeroFlag <= aluZero;
            memGranted <= (stateNext == MEMORY) && (memGranted || execGrant);
        end
    end

    always_ff @(posedge reset)
    begin
        if (take)
            ir <= instruction;
        if (state == OPERAND)
        begin
            memAddr <= rxData;
            memWdata <= {8'd0, ryData};
        end
    end

endmodule

/* hdl/fetchUnit.sv */
`timescale 1ns/100ps

module fetchUnit import cpuPkg::*; (
    input  logic        reset,
    input  logic        clk,
    input  logic        run,
    output memReq_t     fetchReq,
    input  logic        fetchGrant,
    input  logic        fetchRdValid,
    input  logic [15:0] rdata,
    input  logic        take,
    input  logic        redirect,
    input  logic [7:0]  target,
    output instrWord_t  instruction,
    output logic        instrValid,
    output logic [7:0]  nextPc
);

    logic [7:0] pc;
    logic       inFlight;
    logic       flush;

    assign flush = redirect || !run;

    // Ask again as soon as the buffer empties or is being taken
    assign fetchReq = '{req: run && !redirect && !inFlight && (!instrValid || take),
                        we: 1'b0, addr: pc, wdata: 16'd0};

    always_ff @(posedge reset or posedge clk)
    begin
        if (clk)
        begin
            pc <= 8'd0;
            instrValid <= 1'b0;
            inFlight <= 1'b0;
            nextPc <= 8'd0;
        end
        else
        begin
            inFlight <= fetchGrant || (inFlight && !fetchRdValid);
            if (flush)
            begin
                pc <= run ? target : 8'd0;
                // Word arriving now belongs to the old path
                instrValid <= 1'b0;
            end
            else
            begin
                if (fetchGrant)
                    pc <= pc + 8'd1;
                if (fetchRdValid)
                begin
                    instrValid <= 1'b1;
                    nextPc <= pc;
                end
                else if (take)
                    instrValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge reset)
    begin
        if (fetchRdValid)
            instruction <= rdata;
    end

endmodule

/* hdl/memArbiter.sv */
`timescale 1ns/100ps

module memArbiter import cpuPkg::*; #(
    parameter int MEM_DEPTH_LOG2 = 8
) (
    input  logic        reset,
    input  logic        clk,
    input  memReq_t     hostReq,
    input  memReq_t     execReq,
    input  memReq_t     fetchReq,
    output logic        hostGrant,
    output logic        execGrant,
    output logic        fetchGrant,
    output logic        hostRdValid,
    output logic        execRdValid,
    output logic        fetchRdValid,
    output memReq_t     memReq,
    input  logic [15:0] memRdata,
    output logic [15:0] rdata
);

    typedef struct packed {
        logic host;
        logic exec;
        logic fetch;
    } owner_t;

    // Upper address bits fall away for a smaller memory
    localparam logic [7:0] addrMask = 8'((1 << MEM_DEPTH_LOG2) - 1);

    memReq_t winner;
    owner_t  readOwner;

    ////////////////////////////////////////////////////////////
    // Host first, then execution, then fetch
    ////////////////////////////////////////////////////////////
    assign hostGrant = hostReq.req;
    assign execGrant = execReq.req && !hostReq.req;
    assign fetchGrant = fetchReq.req && !hostReq.req && !execReq.req;

    always_comb
    begin
        if (hostGrant)
            winner = hostReq;
        else if (execGrant)
            winner = execReq;
        else
            winner = fetchReq;
        memReq = winner;
        memReq.addr = winner.addr & addrMask;
    end

    // Remember who gets the word coming out next cycle
    always_ff @(posedge reset or posedge clk)
    begin
        if (clk)
            readOwner <= '0;
        else
        begin
            readOwner.host <= hostGrant && !hostReq.we;
            readOwner.exec <= execGrant && !execReq.we;
            readOwner.fetch <= fetchGrant && !fetchReq.we;
        end
    end

    assign hostRdValid = readOwner.host;
    assign execRdValid = readOwner.exec;
    assign fetchRdValid = readOwner.fetch;
    assign rdata = memRdata;

endmodule

/* hdl/microCore.sv */
`timescale 1ns/100ps

module microCore import cpuPkg::*; #(
    parameter int MEM_DEPTH_LOG2 = 8
) (
    input  logic        reset,
    input  logic        clk,
    input  logic        run,
    input  memReq_t     hostReq,
    output logic        hostGrant,
    output logic        hostRdValid,
    output logic [15:0] hostRdata,
    output logic [7:0]  r0Data,
    output logic        halted
);

    memReq_t     fetchReq;
    memReq_t     execReq;
    memReq_t     memReq;
    logic        fetchGrant;
    logic        execGrant;
    logic        fetchRdValid;
    logic        execRdValid;
    logic [15:0] memRdata;
    logic [15:0] rdata;
    instrWord_t  instruction;
    logic        instrValid;
    logic        take;
    logic        redirect;
    logic [7:0]  target;
    logic [7:0]  nextPc;
    logic [2:0]  rxAddr;
    logic [2:0]  ryAddr;
    logic [2:0]  rzAddr;
    wrSel_t      wrSel;
    logic [7:0]  wrData;
    aluOp_t      aluOp;
    logic [7:0]  aluResult;
    logic        aluZero;
    logic [7:0]  rxData;
    logic [7:0]  ryData;

    // Read data is shared, each peer has its own valid strobe
    assign hostRdata = rdata;

    ////////////////////////////////////////////////////////////
    // Core
    ////////////////////////////////////////////////////////////
    fetchUnit i_fetchUnit (
        .reset(reset), .clk(clk), .run(run),
        .fetchReq(fetchReq), .fetchGrant(fetchGrant), .fetchRdValid(fetchRdValid),
        .rdata(rdata), .take(take), .redirect(redirect), .target(target),
        .instruction(instruction), .instrValid(instrValid), .nextPc(nextPc)
    );

    execUnit i_execUnit (
        .reset(reset), .clk(clk), .run(run),
        .instruction(instruction), .instrValid(instrValid),
        .take(take), .redirect(redirect), .target(target),
        .rxAddr(rxAddr), .ryAddr(ryAddr), .rzAddr(rzAddr),
        .wrSel(wrSel), .wrData(wrData), .aluOp(aluOp),
        .aluResult(aluResult), .aluZero(aluZero), .rxData(rxData), .ryData(ryData),
        .execReq(execReq), .execGrant(execGrant), .execRdValid(execRdValid),
        .rdata(rdata), .halted(halted)
    );

    registerFile i_registerFile (
        .reset(reset), .clk(clk),
        .rxAddr(rxAddr), .ryAddr(ryAddr), .rzAddr(rzAddr), .wrSel(wrSel),
        .dataIn(wrData), .result(aluResult), .link(nextPc),
        .rxData(rxData), .ryData(ryData), .r0Data(r0Data)
    );

    aluUnit i_aluUnit (
        .aluOp(aluOp), .a(rxData), .b(ryData), .result(aluResult), .zero(aluZero)
    );

    ////////////////////////////////////////////////////////////
    // Shared memory
    ////////////////////////////////////////////////////////////
    memArbiter #(.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)) i_memArbiter (
        .reset(reset), .clk(clk),
        .hostReq(hostReq), .execReq(execReq), .fetchReq(fetchReq),
        .hostGrant(hostGrant), .execGrant(execGrant), .fetchGrant(fetchGrant),
        .hostRdValid(hostRdValid), .execRdValid(execRdValid),
        .fetchRdValid(fetchRdValid),
        .memReq(memReq), .memRdata(memRdata), .rdata(rdata)
    );

    unifiedMemory #(.MEM_DEPTH_LOG2(MEM_DEPTH_LOG2)) i_unifiedMemory (
        .reset(reset), .clk(clk), .memReq(memReq), .memRdata(memRdata)
    );

endmodule

/* hdl/registerFile.sv */
`timescale 1ns/100ps

module registerFile import cpuPkg::*; (
    input  logic       reset,
    input  logic       clk,
    input  logic [2:0] rxAddr,
    input  logic [2:0] ryAddr,
    input  logic [2:0] rzAddr,
    input  wrSel_t     wrSel,
    input  logic [7:0] dataIn,
    input  logic [7:0] result,
    input  logic [7:0] link,
    output logic [7:0] rxData,
    output logic [7:0] ryData,
    output logic [7:0] r0Data
);

    logic [7:0] regs [NUM_REGS];

    ////////////////////////////////////////////////////////////
    // Registered read ports
    ////////////////////////////////////////////////////////////
    always_ff @(posedge reset or posedge clk)
    begin
        if (clk)
        begin
            rxData <= 8'd0;
            ryData <= 8'd0;
            r0Data <= 8'd0;
        end
        else
        begin
            rxData <= regs[rxAddr];
            ryData <= regs[ryAddr];
            // Monitor copy of R0 for the host side
            r0Data <= regs[0];
        end
    end

    ////////////////////////////////////////////////////////////
    // One write per cycle
    ////////////////////////////////////////////////////////////
    always_ff @(posedge reset or posedge clk)
    begin
        if (clk)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= 8'd0;
            end
        end
        else
        begin
            case (wrSel)
                RESULT:  regs[0] <= result;
                DATA:    regs[rzAddr] <= dataIn;
                // Return address always lands in R7
                LINK:    regs[NUM_REGS - 1] <= link;
                default: ;
            endcase
        end
    end

endmodule

/* hdl/unifiedMemory.sv */
`timescale 1ns/100ps

module unifiedMemory import cpuPkg::*; #(
    parameter int MEM_DEPTH_LOG2 = 8
) (
    input  logic        reset,
    input  logic        clk,
    input  memReq_t     memReq,
    output logic [15:0] memRdata
);

    // Never more words than an 8-bit address reaches
    localparam int memDepth = ((2 ** MEM_DEPTH_LOG2) < MEM_WORDS) ?
                              (2 ** MEM_DEPTH_LOG2) : MEM_WORDS;
    localparam int indexBits = $clog2(memDepth);

    logic [15:0]          storage [memDepth];
    logic [indexBits-1:0] index;

    assign index = memReq.addr[indexBits-1:0];

    ////////////////////////////////////////////////////////////
    // Write at the request, read one cycle later
    ////////////////////////////////////////////////////////////
    always_ff @(posedge reset)
    begin
        if (memReq.req && memReq.we)
            storage[index] <= memReq.wdata;
    end

    // Output holds until the next read
    always_ff @(posedge reset or posedge clk)
    begin
        if (clk)
            memRdata <= 16'd0;
        else if (memReq.req && !memReq.we)
            memRdata <= storage[index];
    end

endmodule

/* tests/coreTrace.txt */
# kind addr word : W writes word through the host port, E reads it back and compares
# kind value     : R compares r0Data, G raises run until halted, S drops run
W F0 1234
W F1 ABCD
W F2 0F0F
E F0 1234
E F1 ABCD
E F2 0F0F
# Data for LD and the marker that the skipped store must leave alone
W 40 0037
W 85 00EE
# Program 1: ALU chain, LD, JZ taken and not taken, CALL and JR R7
W 00 525A
W 01 543C
W 02 0050
W 03 1010
W 04 4010
W 05 3008
W 06 2010
W 07 5680
W 08 70C0
W 09 5840
W 0A 6B00
W 0B 0168
W 0C 5681
W 0D 70C0
W 0E 5CAA
W 0F 1168
W 10 9012
W 11 5CBB
W 12 5682
W 13 70F0
W 14 0168
W 15 9017
W 16 5CCC
W 17 5683
W 18 70F0
W 19 A020
W 1A 5684
W 1B 70C8
W 1C C000
W 20 5277
W 21 B1C0
W 22 5685
W 23 70C8
G
R 6E
E 80 003C
E 81 006E
E 82 00AA
E 83 00CC
E 84 0077
E 85 00EE
S
# Program 2 restarts at 0 and uses R1 and R6 left by program 1
W 00 4070
W 01 5686
W 02 70C0
W 03 C000
G
R BB
E 86 00BB
S

/* tests/tbMicroCore.sv */
`timescale 1ns/100ps

module tbMicroCore import cpuPkg::*; ();

    localparam string traceFile = "tests/coreTrace.txt";

    logic        reset = 1'b0;
    logic        clk;
    logic        run;
    memReq_t     hostReq;
    logic        hostGrant;
    logic        hostRdValid;
    logic [15:0] hostRdata;
    logic [7:0]  r0Data;
    logic        halted;

    integer traceFd;
    integer checkCount = 0;
    integer mismatchCount = 0;
    integer failCount = 0;
    integer cycleCount = 0;
    integer cycleLimit = 0;

    // Clock named reset, 40 ns period
    always #20 reset = ~reset;

    microCore #(.MEM_DEPTH_LOG2(8)) i_microCore (
        .reset(reset), .clk(clk), .run(run), .hostReq(hostReq),
        .hostGrant(hostGrant), .hostRdValid(hostRdValid), .hostRdata(hostRdata),
        .r0Data(r0Data), .halted(halted)
    );

    task automatic printCounts();
        $display("Checks: %0d  mismatches: %0d  other errors: %0d",
                 checkCount, mismatchCount, failCount);
    endtask

    always @(posedge reset)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit)
        begin
            failCount++;
            $display("Timeout after %0d cycles, the trace did not finish", cycleLimit);
            printCounts();
            $display("ERRORS FOUND");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Trace file helpers
    ////////////////////////////////////////////////////////////
    task automatic skipLine(input integer fd);
        integer ch;
        ch = 0;
        while (ch != 10 && ch != -1)
            ch = $fgetc(fd);
    endtask

    // 64 cycles per line plus 500 for every program run
    task automatic measureTrace();
        integer fd;
        integer code;
        integer lines;
        integer goLines;
        logic [7:0] kind;
        lines = 0;
        goLines = 0;
        fd = $fopen(traceFile, "r");
        if (fd != 0)
        begin
            code = $fscanf(fd, " %c", kind);
            while (code == 1)
            begin
                lines++;
                if (kind == "G")
                    goLines++;
                skipLine(fd);
                code = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
        cycleLimit = 64 * lines + 500 * goLines;
    endtask

    ////////////////////////////////////////////////////////////
    // Host port and run control
    ////////////////////////////////////////////////////////////
    // Returns on the falling edge after the rising edge that granted
    task automatic waitHostGrant();
        do
            @(negedge reset);
        while (!hostGrant);
    endtask

    task automatic hostWrite(input logic [7:0] addr, input logic [15:0] word);
        hostReq = '{req: 1'b1, we: 1'b1, addr: addr, wdata: word};
        waitHostGrant();
        hostReq = '0;
    endtask

    task automatic hostRead(input logic [7:0] addr, input logic [15:0] expected);
        logic        valid;
        logic [15:0] word;
        hostReq = '{req: 1'b1, we: 1'b0, addr: addr, wdata: 16'd0};
        waitHostGrant();
        // One cycle after the grant the word is out
        valid = hostRdValid;
        word = hostRdata;
        hostReq = '0;
        checkCount++;
        if (!valid)
        begin
            failCount++;
            $display("Host read of address %h got no read valid one cycle after its grant",
                     addr);
        end
        else if (word !== expected)
        begin
            mismatchCount++;
            $display("Mismatch at %0t: memory[%h] expected %h, got %h",
                     $time, addr, expected, word);
        end
    endtask

    task automatic runProgram();
        if (halted)
        begin
            failCount++;
            $display("Halted was still high when run was raised again");
        end
        run = 1'b1;
        do
            @(negedge reset);
        while (!halted);
    endtask

    task automatic checkR0(input logic [7:0] expected);
        checkCount++;
        if (r0Data !== expected)
        begin
            mismatchCount++;
            $display("Mismatch at %0t: R0 expected %h, got %h", $time, expected, r0Data);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        integer     code;
        integer     wanted;
        integer     lineNumber;
        logic       moreLines;
        logic [7:0] kind;
        logic [15:0] argA;
        logic [15:0] argB;

        clk = 1'b1;
        run = 1'b0;
        hostReq = '0;
        lineNumber = 0;
        measureTrace();
        traceFd = $fopen(traceFile, "r");
        moreLines = (traceFd != 0);
        if (traceFd == 0)
        begin
            failCount++;
            $display("Could not open the trace file %s", traceFile);
        end
        else
        begin
            repeat (10) @(negedge reset);
            clk = 1'b0;
        end

        while (moreLines)
        begin
            code = $fscanf(traceFd, " %c", kind);
            if (code != 1)
                moreLines = 1'b0;
            else
            begin
                lineNumber++;
                argA = 16'd0;
                argB = 16'd0;
                if (kind == "#")
                    wanted = -1;
                else if (kind == "W" || kind == "E")
                    wanted = 2;
                else if (kind == "R")
                    wanted = 1;
                else
                    wanted = 0;
                if (wanted == 2)
                    code = $fscanf(traceFd, "%h %h", argA, argB);
                else if (wanted == 1)
                    code = $fscanf(traceFd, "%h", argA);
                else
                    code = wanted;
                skipLine(traceFd);
                if (code != wanted)
                begin
                    failCount++;
                    $display("Trace line %0d is missing a field", lineNumber);
                end
                else if (wanted >= 0)
                begin
                    @(negedge reset);
                    case (kind)
                        "W":     hostWrite(argA[7:0], argB);
                        "E":     hostRead(argA[7:0], argB);
                        "G":     runProgram();
                        "R":     checkR0(argA[7:0]);
                        "S":     run = 1'b0;
                        default:
                        begin
                            failCount++;
                            $display("Trace line %0d has an unknown kind %c", lineNumber, kind);
                        end
                    endcase
                end
            end
        end

        if (traceFd != 0)
            $fclose(traceFd);
        if (checkCount == 0)
        begin
            failCount++;
            $display("The trace held no checks");
        end
        printCounts();
        if (mismatchCount == 0 && failCount == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* vlog.f */
hdl/cpuPkg.sv
hdl/aluUnit.sv
hdl/registerFile.sv
hdl/fetchUnit.sv
hdl/execUnit.sv
hdl/memArbiter.sv
hdl/unifiedMemory.sv
hdl/microCore.sv
tests/tbMicroCore.sv
